/* hdl/vector_defines.svh */
`ifndef VECTOR_DEFINES_SVH
`define VECTOR_DEFINES_SVH

// fp16 elements per vector register
`define VEC_VLEN 4

// vector register count
`define VEC_NUM_REGS 8

// per-lane command queue depth, also the sender's starting credits
`define VEC_CMD_DEPTH 2

// register file requesters: host, lane 0, lane 1
`define VEC_NUM_REQ 3

`endif

/* hdl/vector_pkg.sv */
`default_nettype none

`include "vector_defines.svh"

package vector_pkg;

    // half precision fields, msb first
    typedef struct packed {
        logic       sign;
        logic [4:0] exp;  // biased exponent
        logic [9:0] frac; // implicit one not stored
    } fp16_t;

    // register number, 3 bits for eight registers
    typedef logic [$clog2(`VEC_NUM_REGS)-1:0] vreg_idx_t;

    // element 0 in the low 16 bits
    typedef fp16_t [`VEC_VLEN-1:0] vec_t;

endpackage

`default_nettype wire

/* hdl/vaddsub.sv */
`timescale 1ns/1ps
`default_nettype none

module vaddsub import vector_pkg::*; (
    input  fp16_t a,
    input  fp16_t b,
    input  logic  sub, // flips sign of b
    output fp16_t sum
);

    logic        sign_a;
    logic        sign_b;     // effective sign after sub
    logic        sign_r;
    logic [4:0]  exp_diff;
    logic [4:0]  exp_r;
    logic [12:0] frac_a_ext; // 1.frac plus two guard bits
    logic [12:0] frac_b_ext;
    logic [13:0] frac_sum;   // extra bit for carry out

    assign sign_a = a.sign;
    assign sign_b = sub ? ~b.sign : b.sign;

    always_comb begin
        // align smaller exponent to the larger one
        if (a.exp > b.exp) begin
            exp_diff   = a.exp - b.exp;
            exp_r      = a.exp;
            frac_a_ext = {1'b1, a.frac, 2'b00};
            frac_b_ext = {1'b1, b.frac, 2'b00} >> exp_diff; // bits past guard are lost
        end else begin
            exp_diff   = b.exp - a.exp; // zero when exponents match
            exp_r      = b.exp;
            frac_b_ext = {1'b1, b.frac, 2'b00};
            frac_a_ext = {1'b1, a.frac, 2'b00} >> exp_diff;
        end

        // same effective sign adds, otherwise subtract smaller magnitude
        if (sign_a == sign_b) begin
            frac_sum = {1'b0, frac_a_ext} + {1'b0, frac_b_ext};
            sign_r   = sign_a;
        end else if (frac_a_ext >= frac_b_ext) begin
            frac_sum = {1'b0, frac_a_ext} - {1'b0, frac_b_ext};
            sign_r   = sign_a; // a dominates, ties keep a's sign
        end else begin
            frac_sum = {1'b0, frac_b_ext} - {1'b0, frac_a_ext};
            sign_r   = sign_b;
        end

        // normalize so the leading one lands on bit 12
        for (int i = 0; i < 12; i++) begin
            if (frac_sum[13]) begin
                frac_sum = frac_sum >> 1; // carry out, one step right
                exp_r    = exp_r + 5'd1;
            end else if (!frac_sum[12] && (exp_r > 5'd0)) begin
                frac_sum = frac_sum << 1;
                exp_r    = exp_r - 5'd1;
            end
        end
    end

    // truncate, guard bits dropped
    assign sum = {sign_r, exp_r, frac_sum[11:2]};

endmodule

`default_nettype wire

/* hdl/vector_lane.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vector_defines.svh"

module vector_lane import vector_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_valid,
    input  logic      cmd_sub,
    input  vreg_idx_t cmd_vd,
    input  vreg_idx_t cmd_vs1,
    input  vreg_idx_t cmd_vs2,
    output logic      cmd_credit,
    output logic      req,
    output logic      we,
    output vreg_idx_t addr_a,
    output vreg_idx_t addr_b,
    output vec_t      wdata,
    input  logic      gnt,
    input  logic      rvalid,
    input  vec_t      rdata_a,
    input  vec_t      rdata_b
);

    localparam int DEPTH = `VEC_CMD_DEPTH;
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    // per head command: read, wait for data, write back
    typedef enum logic [1:0] {ST_RD, ST_WAIT, ST_WR} state_t;

    state_t             state;
    logic               q_sub [DEPTH];
    vreg_idx_t          q_vd  [DEPTH];
    vreg_idx_t          q_vs1 [DEPTH];
    vreg_idx_t          q_vs2 [DEPTH];
    logic [PTR_W-1:0]   wr_ptr, rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               full, empty, push, pop;
    logic               rd_gnt_q; // own read granted last cycle
    logic               data_ok;
    vec_t               sum_v;    // element-wise unit outputs
    vec_t               res_q;

    assign full    = (count == CNT_W'(DEPTH));
    assign empty   = (count == '0);
    assign push    = cmd_valid && !full;          // no credit means no push
    assign pop     = (state == ST_WR) && gnt;     // write landed
    assign data_ok = (state == ST_WAIT) && rvalid && rd_gnt_q;

    // queue payload, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            q_sub[wr_ptr] <= cmd_sub;
            q_vd[wr_ptr]  <= cmd_vd;
            q_vs1[wr_ptr] <= cmd_vs1;
            q_vs2[wr_ptr] <= cmd_vs2;
        end
        if (data_ok) res_q <= sum_v; // capture sum with our own operands
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_RD;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            rd_gnt_q   <= 1'b0;
            cmd_credit <= 1'b0;
        end else begin
            rd_gnt_q   <= gnt && !we;
            cmd_credit <= pop; // one cycle after the write edge
            if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count <= count + CNT_W'(push) - CNT_W'(pop);
            case (state)
                ST_RD:   if (gnt)     state <= ST_WAIT;
                ST_WAIT: if (data_ok) state <= ST_WR;
                ST_WR:   if (gnt)     state <= ST_RD;
                default:              state <= ST_RD;
            endcase
        end
    end

    // request held until granted
    assign req    = ((state == ST_RD) && !empty) || (state == ST_WR);
    assign we     = (state == ST_WR);
    assign addr_a = we ? q_vd[rd_ptr] : q_vs1[rd_ptr]; // write address rides on port a
    assign addr_b = q_vs2[rd_ptr];
    assign wdata  = res_q;

    for (genvar i = 0; i < `VEC_VLEN; i++) begin : g_elem
        vaddsub u_vaddsub (
            .a   (rdata_a[i]),
            .b   (rdata_b[i]),
            .sub (q_sub[rd_ptr]),
            .sum (sum_v[i])
        );
    end

endmodule

`default_nettype wire

/* hdl/vreg_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vector_defines.svh"

module vreg_arbiter import vector_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req    [`VEC_NUM_REQ],
    input  logic      we     [`VEC_NUM_REQ],
    input  vreg_idx_t addr_a [`VEC_NUM_REQ],
    input  vreg_idx_t addr_b [`VEC_NUM_REQ],
    input  vec_t      wdata  [`VEC_NUM_REQ],
    input  logic      rvalid,      // from register file
    output logic      gnt    [`VEC_NUM_REQ],
    output logic      rf_en,
    output logic      rf_we,
    output vreg_idx_t rf_addr_a,
    output vreg_idx_t rf_addr_b,
    output vec_t      rf_wdata,
    output logic      host_rvalid  // rvalid owned by requester 0
);

    localparam int N     = `VEC_NUM_REQ;
    localparam int IDX_W = $clog2(N);

    logic [IDX_W-1:0] prio; // highest priority requester this cycle
    logic [IDX_W-1:0] sel;
    logic             host_gnt_q;

    // scan from lowest priority up so the highest pending one wins
    always_comb begin
        int idx;
        sel   = prio;
        rf_en = 1'b0;
        for (int i = 0; i < N; i++) gnt[i] = 1'b0;
        for (int k = N - 1; k >= 0; k--) begin
            idx = int'(prio) + k;
            if (idx >= N) idx = idx - N; // wrap
            if (req[idx]) begin
                sel   = IDX_W'(idx);
                rf_en = 1'b1;
            end
        end
        if (rf_en) gnt[sel] = 1'b1;
    end

    // granted request onto the shared port
    assign rf_we     = rf_en && we[sel];
    assign rf_addr_a = addr_a[sel];
    assign rf_addr_b = addr_b[sel];
    assign rf_wdata  = wdata[sel];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prio       <= '0;
            host_gnt_q <= 1'b0;
        end else begin
            if (rf_en) prio <= (sel == IDX_W'(N - 1)) ? '0 : sel + 1'b1; // move past winner
            host_gnt_q <= gnt[0] && !we[0]; // host read granted
        end
    end

    assign host_rvalid = rvalid && host_gnt_q;

endmodule

`default_nettype wire

/* hdl/vreg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vector_defines.svh"

module vreg_file import vector_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      rf_en,
    input  logic      rf_we,
    input  vreg_idx_t rf_addr_a,  // also the write address
    input  vreg_idx_t rf_addr_b,
    input  vec_t      rf_wdata,
    output vec_t      rdata_a,
    output vec_t      rdata_b,
    output logic      rvalid
);

    vec_t mem [`VEC_NUM_REGS];
    logic rd_en;

    assign rd_en = rf_en && !rf_we;

    // storage and read strobe, cleared at reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `VEC_NUM_REGS; i++) mem[i] <= '0;
            rvalid <= 1'b0;
        end else begin
            if (rf_en && rf_we) mem[rf_addr_a] <= rf_wdata;
            rvalid <= rd_en; // single cycle pulse per read
        end
    end

    // two read ports, registered
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata_a <= mem[rf_addr_a];
            rdata_b <= mem[rf_addr_b];
        end
    end

endmodule

`default_nettype wire

/* hdl/vector_unit_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vector_defines.svh"

module vector_unit_top import vector_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    // lane 0 commands
    input  logic      l0_cmd_valid,
    input  logic      l0_cmd_sub,
    input  vreg_idx_t l0_cmd_vd,
    input  vreg_idx_t l0_cmd_vs1,
    input  vreg_idx_t l0_cmd_vs2,
    output logic      l0_cmd_credit,
    // lane 1 commands
    input  logic      l1_cmd_valid,
    input  logic      l1_cmd_sub,
    input  vreg_idx_t l1_cmd_vd,
    input  vreg_idx_t l1_cmd_vs1,
    input  vreg_idx_t l1_cmd_vs2,
    output logic      l1_cmd_credit,
    // host register access
    input  logic      host_req,
    input  logic      host_we,
    input  vreg_idx_t host_addr_a,
    input  vreg_idx_t host_addr_b,
    input  vec_t      host_wdata,
    output logic      host_gnt,
    output logic      host_rvalid,
    output vec_t      host_rdata_a,
    output vec_t      host_rdata_b
);

    // requester 0 host, 1 lane 0, 2 lane 1
    logic      req    [`VEC_NUM_REQ];
    logic      we     [`VEC_NUM_REQ];
    vreg_idx_t addr_a [`VEC_NUM_REQ];
    vreg_idx_t addr_b [`VEC_NUM_REQ];
    vec_t      wdata  [`VEC_NUM_REQ];
    logic      gnt    [`VEC_NUM_REQ];
    logic      rf_en, rf_we;
    vreg_idx_t rf_addr_a, rf_addr_b;
    vec_t      rf_wdata;
    vec_t      rdata_a, rdata_b;     // broadcast to every requester
    logic      rvalid;

    assign req[0]    = host_req;
    assign we[0]     = host_we;
    assign addr_a[0] = host_addr_a;
    assign addr_b[0] = host_addr_b;
    assign wdata[0]  = host_wdata;
    assign host_gnt     = gnt[0];
    assign host_rdata_a = rdata_a;
    assign host_rdata_b = rdata_b;

    vector_lane u_lane0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (l0_cmd_valid),
        .cmd_sub    (l0_cmd_sub),
        .cmd_vd     (l0_cmd_vd),
        .cmd_vs1    (l0_cmd_vs1),
        .cmd_vs2    (l0_cmd_vs2),
        .cmd_credit (l0_cmd_credit),
        .req        (req[1]),
        .we         (we[1]),
        .addr_a     (addr_a[1]),
        .addr_b     (addr_b[1]),
        .wdata      (wdata[1]),
        .gnt        (gnt[1]),
        .rvalid     (rvalid),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b)
    );

    vector_lane u_lane1 (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_valid  (l1_cmd_valid),
        .cmd_sub    (l1_cmd_sub),
        .cmd_vd     (l1_cmd_vd),
        .cmd_vs1    (l1_cmd_vs1),
        .cmd_vs2    (l1_cmd_vs2),
        .cmd_credit (l1_cmd_credit),
        .req        (req[2]),
        .we         (we[2]),
        .addr_a     (addr_a[2]),
        .addr_b     (addr_b[2]),
        .wdata      (wdata[2]),
        .gnt        (gnt[2]),
        .rvalid     (rvalid),
        .rdata_a    (rdata_a),
        .rdata_b    (rdata_b)
    );

    vreg_arbiter u_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .we          (we),
        .addr_a      (addr_a),
        .addr_b      (addr_b),
        .wdata       (wdata),
        .rvalid      (rvalid),
        .gnt         (gnt),
        .rf_en       (rf_en),
        .rf_we       (rf_we),
        .rf_addr_a   (rf_addr_a),
        .rf_addr_b   (rf_addr_b),
        .rf_wdata    (rf_wdata),
        .host_rvalid (host_rvalid) // host read data qualifier
    );

    vreg_file u_vreg_file (
        .clk       (clk),
        .rst_n     (rst_n),
        .rf_en     (rf_en),
        .rf_we     (rf_we),
        .rf_addr_a (rf_addr_a),
        .rf_addr_b (rf_addr_b),
        .rf_wdata  (rf_wdata),
        .rdata_a   (rdata_a),
        .rdata_b   (rdata_b),
        .rvalid    (rvalid)
    );

endmodule

`default_nettype wire

/* sim/vector_unit_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vector_defines.svh"

module vector_unit_properties (
    input logic                    clk,
    input logic                    rst_n,
    input logic [`VEC_NUM_REQ-1:0] req,
    input logic [`VEC_NUM_REQ-1:0] gnt,
    input logic                    rf_en,
    input logic                    rf_we,
    input logic                    rvalid,
    input logic [1:0]              cmd_valid,  // lane 1, lane 0
    input logic [1:0]              cmd_credit
);

    logic [3:0] held [2]; // commands sent but not yet credited
    int         fail_count = 0; // assertions that fired so far

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            held[0] <= '0;
            held[1] <= '0;
        end else begin
            for (int l = 0; l < 2; l++)
                held[l] <= held[l] + 4'(cmd_valid[l]) - 4'(cmd_credit[l]);
        end
    end

    a_gnt_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gnt))
        else begin
            fail_count++;
            $error("more than one register file grant");
        end
    a_gnt_req: assert property (@(posedge clk) disable iff (!rst_n) (gnt & ~req) == '0)
        else begin
            fail_count++;
            $error("grant without request");
        end
    a_rd_timing: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid == $past(rf_en && !rf_we))
        else begin
            fail_count++;
            $error("rvalid not one cycle after a granted read");
        end
    a_l0_credit: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid[0] |-> held[0] < 4'(`VEC_CMD_DEPTH))
        else begin
            fail_count++;
            $error("lane 0 command sent without credit");
        end
    a_l1_credit: assert property (@(posedge clk) disable iff (!rst_n)
        cmd_valid[1] |-> held[1] < 4'(`VEC_CMD_DEPTH))
        else begin
            fail_count++;
            $error("lane 1 command sent without credit");
        end

endmodule

// arbiter and both lanes live in the top level
bind vector_unit_top vector_unit_properties i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .req        ({req[2], req[1], req[0]}),
    .gnt        ({gnt[2], gnt[1], gnt[0]}),
    .rf_en      (rf_en),
    .rf_we      (rf_we),
    .rvalid     (rvalid),
    .cmd_valid  ({l1_cmd_valid, l0_cmd_valid}),
    .cmd_credit ({l1_cmd_credit, l0_cmd_credit})
);

`default_nettype wire

/* sim/vector_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "vector_defines.svh"

module vector_unit_tb import vector_pkg::*; ();

    localparam int NUM_TESTS = 6;
    localparam int WAIT_MAX  = 200; // cycles any single handshake may take
    // operand and result vectors for the exact cases, element 0 in the low bits
    localparam vec_t ADD_A = 64'h3800_4000_3E00_3C00; // 1.0 1.5 2.0 0.5
    localparam vec_t ADD_B = 64'h3800_4000_3400_3C00; // 1.0 0.25 2.0 0.5
    localparam vec_t ADD_R = 64'h3C00_4400_3F00_4000; // 2.0 1.75 4.0 1.0
    localparam vec_t SUB_A = 64'h4000_4000_4200_3C00; // 1.0 3.0 2.0 2.0
    localparam vec_t SUB_B = 64'h4400_3800_3C00_4200; // 3.0 1.0 0.5 4.0
    localparam vec_t SUB_R = 64'hC000_3E00_4000_C000; // -2.0 2.0 1.5 -2.0

    logic clk, rst_n;
    logic l0_cmd_valid, l0_cmd_sub, l0_cmd_credit;
    logic l1_cmd_valid, l1_cmd_sub, l1_cmd_credit;
    vreg_idx_t l0_cmd_vd, l0_cmd_vs1, l0_cmd_vs2;
    vreg_idx_t l1_cmd_vd, l1_cmd_vs1, l1_cmd_vs2;
    logic host_req, host_we, host_gnt, host_rvalid;
    vreg_idx_t host_addr_a, host_addr_b;
    vec_t host_wdata, host_rdata_a, host_rdata_b;

    int          errors = 0;
    int          issued [2] = '{0, 0};
    int          returned [2] = '{0, 0}; // credit pulses seen per lane
    logic [31:0] lcg_state = 32'h8ddb_d436;
    vec_t        shadow [`VEC_NUM_REGS];  // last value the host wrote

    vector_unit_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (l0_cmd_credit) returned[0]++;
        if (l1_cmd_credit) returned[1]++;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // normal value, exponent kept in 5..25 so sums stay in range
    function automatic fp16_t rand_fp16();
        fp16_t f;
        lcg_state = lcg_next(lcg_state);
        f.sign = lcg_state[31];
        f.exp  = 5'(5 + (lcg_state[27:20] % 21));
        f.frac = lcg_state[13:4];
        return f;
    endfunction

    function automatic vec_t rand_vec();
        vec_t v;
        for (int e = 0; e < `VEC_VLEN; e++) v[e] = rand_fp16();
        return v;
    endfunction

    // significands as integers: 1.frac scaled by four for two guard bits
    function automatic fp16_t fp16_ref(input fp16_t a, input fp16_t b, input logic sub);
        logic       sa, sb, s;
        logic [4:0] e;
        int         ma, mb, m, n;
        sa = a.sign;
        sb = b.sign ^ sub;
        ma = 4096 + int'(a.frac) * 4;
        mb = 4096 + int'(b.frac) * 4;
        if (a.exp > b.exp) begin
            e  = a.exp;
            mb = mb >> (a.exp - b.exp);
        end else begin
            e  = b.exp;
            ma = ma >> (b.exp - a.exp);
        end
        if (sa == sb) begin
            m = ma + mb;
            s = sa;
        end else if (ma >= mb) begin
            m = ma - mb;
            s = sa;
        end else begin
            m = mb - ma;
            s = sb;
        end
        if (m >= 8192) begin // carry out
            m = m >> 1;
            e = e + 5'd1;
        end
        n = 0;
        while (m < 4096 && e != 5'd0 && n < 12) begin
            m = m * 2;
            e = e - 5'd1;
            n++;
        end
        return {s, e, 10'(m >> 2)}; // truncated
    endfunction

    function automatic vec_t vec_ref(input vec_t a, input vec_t b, input logic sub);
        vec_t r;
        for (int e = 0; e < `VEC_VLEN; e++) r[e] = fp16_ref(a[e], b[e], sub);
        return r;
    endfunction

    function automatic void check_vec(input string name, input vec_t exp, input vec_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s: expected %h, actual %h", name, exp, act);
        end
    endfunction

    function automatic void check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("ERR %s: expected %0d, actual %0d", name, exp, act);
        end
    endfunction

    // tasks start and end 1 ns after a rising edge
    task automatic write_vreg(input vreg_idx_t idx, input vec_t v);
        int n;
        n = 0;
        shadow[idx] = v;
        host_req    = 1'b1;
        host_we     = 1'b1;
        host_addr_a = idx;
        host_wdata  = v;
        @(negedge clk);
        while (!host_gnt && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!host_gnt) begin
            errors++;
            $display("host write to v%0d was never granted", idx);
        end
        @(posedge clk); // write lands here
        #1;
        host_req = 1'b0;
        host_we  = 1'b0;
    endtask

    task automatic read_vreg(input vreg_idx_t ia, input vreg_idx_t ib,
                             output vec_t da, output vec_t db);
        int n;
        n = 0;
        host_req    = 1'b1;
        host_we     = 1'b0;
        host_addr_a = ia;
        host_addr_b = ib;
        @(negedge clk);
        while (!host_gnt && n < WAIT_MAX) begin
            @(negedge clk);
            n++;
        end
        if (!host_gnt) begin
            errors++;
            $display("host read of v%0d was never granted", ia);
        end
        @(posedge clk);
        #1;
        host_req = 1'b0;
        @(negedge clk); // cycle after the grant
        if (!host_rvalid) begin
            errors++;
            $display("host_rvalid did not follow the read grant of v%0d", ia);
        end
        da = host_rdata_a;
        db = host_rdata_b;
        @(posedge clk);
        #1;
    endtask

    task automatic issue_cmd(input int lane, input logic sub, input vreg_idx_t vd,
                             input vreg_idx_t vs1, input vreg_idx_t vs2);
        int n;
        n = 0;
        while (issued[lane] - returned[lane] >= `VEC_CMD_DEPTH && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (issued[lane] - returned[lane] >= `VEC_CMD_DEPTH) begin
            errors++;
            $display("lane %0d got no credit back, command dropped", lane);
        end else begin
            if (lane == 0) begin
                {l0_cmd_valid, l0_cmd_sub} = {1'b1, sub};
                {l0_cmd_vd, l0_cmd_vs1, l0_cmd_vs2} = {vd, vs1, vs2};
            end else begin
                {l1_cmd_valid, l1_cmd_sub} = {1'b1, sub};
                {l1_cmd_vd, l1_cmd_vs1, l1_cmd_vs2} = {vd, vs1, vs2};
            end
            issued[lane]++; // one credit spent
            @(posedge clk);
            #1;
            if (lane == 0) l0_cmd_valid = 1'b0;
            else l1_cmd_valid = 1'b0;
        end
    endtask

    task automatic wait_credit(input int lane);
        int n;
        n = 0;
        while (returned[lane] < issued[lane] && n < WAIT_MAX) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (returned[lane] != issued[lane]) begin
            errors++;
            $display("lane %0d returned %0d credits for %0d commands",
                     lane, returned[lane], issued[lane]);
        end
    endtask

    task automatic test_regfile();
        vec_t ra, rb;
        for (int i = 0; i < `VEC_NUM_REGS; i++) write_vreg(i, rand_vec());
        for (int i = 0; i < `VEC_NUM_REGS; i++) begin
            read_vreg(i, `VEC_NUM_REGS - 1 - i, ra, rb);
            check_vec("regfile_a", shadow[i], ra);
            check_vec("regfile_b", shadow[`VEC_NUM_REGS - 1 - i], rb);
        end
    endtask

    task automatic test_exact_add();
        vec_t ra, rb;
        check_vec("exact_add_model", ADD_R, vec_ref(ADD_A, ADD_B, 1'b0));
        write_vreg(0, ADD_A);
        write_vreg(1, ADD_B);
        issue_cmd(0, 1'b0, 2, 0, 1);
        wait_credit(0);
        read_vreg(2, 2, ra, rb);
        check_vec("exact_add", vec_ref(ADD_A, ADD_B, 1'b0), ra);
    endtask

    task automatic test_sub_sign();
        vec_t ra, rb;
        check_vec("sub_sign_model", SUB_R, vec_ref(SUB_A, SUB_B, 1'b1));
        write_vreg(3, SUB_A);
        write_vreg(4, SUB_B);
        issue_cmd(1, 1'b1, 5, 3, 4); // lane 1
        wait_credit(1);
        read_vreg(5, 5, ra, rb);
        check_vec("sub_sign", vec_ref(SUB_A, SUB_B, 1'b1), ra);
    endtask

    // second command depends on the first one's result
    task automatic test_credit_order();
        vec_t ra, rb, r6;
        int   base;
        base = returned[0];
        r6   = vec_ref(shadow[0], shadow[1], 1'b0);
        issue_cmd(0, 1'b0, 6, 0, 1);
        issue_cmd(0, 1'b1, 7, 6, 0);
        wait_credit(0);
        repeat (10) @(posedge clk);
        #1;
        check_count("credit_order_pulses", `VEC_CMD_DEPTH, returned[0] - base);
        read_vreg(6, 7, ra, rb);
        check_vec("credit_order_first", r6, ra);
        check_vec("credit_order_second", vec_ref(r6, shadow[0], 1'b1), rb);
    endtask

    task automatic test_contention();
        vec_t ra, rb, e4, e5, e6, e7;
        for (int i = 0; i < 4; i++) write_vreg(i, rand_vec());
        e4 = vec_ref(shadow[0], shadow[1], 1'b0); // lane 0 chain
        e5 = vec_ref(e4, shadow[0], 1'b1);
        e4 = vec_ref(e5, shadow[1], 1'b0);
        e5 = vec_ref(e4, shadow[1], 1'b1);
        e6 = vec_ref(shadow[2], shadow[3], 1'b1); // lane 1 chain
        e7 = vec_ref(e6, shadow[2], 1'b0);
        e6 = vec_ref(e7, shadow[3], 1'b1);
        e7 = vec_ref(e6, shadow[3], 1'b0);
        fork
            begin
                issue_cmd(0, 1'b0, 4, 0, 1);
                issue_cmd(0, 1'b1, 5, 4, 0);
                issue_cmd(0, 1'b0, 4, 5, 1);
                issue_cmd(0, 1'b1, 5, 4, 1);
                wait_credit(0);
            end
            begin
                issue_cmd(1, 1'b1, 6, 2, 3);
                issue_cmd(1, 1'b0, 7, 6, 2);
                issue_cmd(1, 1'b1, 6, 7, 3);
                issue_cmd(1, 1'b0, 7, 6, 3);
                wait_credit(1);
            end
            for (int k = 0; k < 8; k++) begin // host polls the sources meanwhile
                read_vreg(k % 4, (k + 1) % 4, ra, rb);
                check_vec("contention_poll", shadow[k % 4], ra);
            end
        join
        read_vreg(4, 5, ra, rb);
        check_vec("contention_lane0_v4", e4, ra);
        check_vec("contention_lane0_v5", e5, rb);
        read_vreg(6, 7, ra, rb);
        check_vec("contention_lane1_v6", e6, ra);
        check_vec("contention_lane1_v7", e7, rb);
    endtask

    task automatic test_random();
        vec_t a, b, ra, rb;
        for (int it = 0; it < 8; it++) begin
            a = rand_vec();
            b = rand_vec();
            write_vreg(0, a);
            write_vreg(1, b);
            issue_cmd(it % 2, it[1], 2, 0, 1); // both lanes, add and sub
            wait_credit(it % 2);
            read_vreg(2, 2, ra, rb);
            check_vec("random", vec_ref(a, b, it[1]), ra);
        end
    endtask

    initial begin
        #(200 * NUM_TESTS * 10);
        $display("watchdog expired after %0d cycles, errors so far %0d",
                 200 * NUM_TESTS, errors);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        {l0_cmd_valid, l0_cmd_sub, l0_cmd_vd, l0_cmd_vs1, l0_cmd_vs2} = '0;
        {l1_cmd_valid, l1_cmd_sub, l1_cmd_vd, l1_cmd_vs1, l1_cmd_vs2} = '0;
        {host_req, host_we, host_addr_a, host_addr_b} = '0;
        host_wdata = '0;
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_regfile();
        test_exact_add();
        test_sub_sign();
        test_credit_order();
        test_contention();
        test_random();
        errors += i_dut.i_props.fail_count; // bound assertion failures
        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
+incdir+hdl
hdl/vector_pkg.sv
hdl/vaddsub.sv
hdl/vector_lane.sv
hdl/vreg_arbiter.sv
hdl/vreg_file.sv
hdl/vector_unit_top.sv
sim/vector_unit_properties.sv
sim/vector_unit_tb.sv

/* Bender.yml */
package:
  name: vector_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/vector_pkg.sv
      - hdl/vaddsub.sv
      - hdl/vector_lane.sv
      - hdl/vreg_arbiter.sv
      - hdl/vreg_file.sv
      - hdl/vector_unit_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - sim/vector_unit_properties.sv
      - sim/vector_unit_tb.sv
